/* fc_data_pkg.sv */
/*
 * Fully connected layer numeric types
 * Activations, weights, bias and accumulator widths plus the lane count
 */

`default_nettype none

package fc_data_pkg;

    // Activations per input tile, also the multiplier count
    localparam int LANES = 4;

    // Input and output feature map element
    typedef logic signed [7:0] act_t;

    // Single weight
    typedef logic signed [7:0] weight_t;

    // LANES weights per memory word, lane 0 in the low byte
    typedef logic [LANES*8-1:0] weight_word_t;

    // Bias as stored in memory
    typedef logic signed [15:0] bias_t;

    // Partial sum, wide enough for the full dot product
    typedef logic signed [23:0] acc_t;

endpackage

`default_nettype wire

/* fc_ctrl_pkg.sv */
/*
 * Fully connected layer control types
 * Memory address widths, channel index and FSM state encodings
 */

`default_nettype none

package fc_ctrl_pkg;

    // Input feature map address, one activation per address
    typedef logic [9:0] in_addr_t;

    // Weight word address, och * ICH_B + input block
    typedef logic [11:0] w_addr_t;

    // Output channel index, also bias and output memory address
    typedef logic [7:0] och_idx_t;

    // Tile sequencer FSM
    typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_WAIT_TILE, S_DRAIN} seq_state_t;

    // MAC engine FSM
    typedef enum logic [1:0] {M_IDLE, M_LOAD, M_MAC} mac_state_t;

endpackage

`default_nettype wire

/* fc_tile_if.sv */
/*
 * Tile command channel from the sequencer to the MAC engine
 */

`default_nettype none

interface fc_tile_if;

    // Command, valid with the tile_start pulse
    logic                  tile_start;
    logic                  first_ich;
    logic                  last_ich;
    fc_ctrl_pkg::in_addr_t in_base;
    fc_ctrl_pkg::w_addr_t  w_base;

    // Completion pulse back to the sequencer
    logic                  tile_done;

    modport seq (output tile_start, first_ich, last_ich, in_base, w_base, input tile_done);
    modport mac (input tile_start, first_ich, last_ich, in_base, w_base, output tile_done);

endinterface

`default_nettype wire

/* fc_tile_sequencer.sv */
/*
 * Tile sequencer for the fully connected layer
 * Walks input and output blocks, issues tile commands, reports run status
 */

`default_nettype none

module fc_tile_sequencer #(
    parameter int ICH_B = 4,
    parameter int OCH_B = 2,
    parameter int OCH_T = 4
) (
    input  logic      clk,
    input  logic      areset,
    input  logic      i_run,
    input  logic      i_layer_written,
    fc_tile_if.seq    tile,
    output logic      o_idle,
    output logic      o_run,
    output logic      o_done,
    output logic      o_en_err
);

    localparam int ICH_W = (ICH_B > 1) ? $clog2(ICH_B) : 1;
    localparam int OCH_W = (OCH_B > 1) ? $clog2(OCH_B) : 1;

    fc_ctrl_pkg::seq_state_t state;
    logic [ICH_W-1:0]        r_ich;
    logic [OCH_W-1:0]        r_och;
    logic                    r_run;
    logic                    r_done;
    logic                    r_err;

    //======================================================================
    // Tile FSM and block counters
    //======================================================================
    always_ff @(posedge clk) begin
        if (areset) begin
            state  <= fc_ctrl_pkg::S_IDLE;
            r_ich  <= '0;
            r_och  <= '0;
            r_run  <= 1'b0;
            r_done <= 1'b0;
            r_err  <= 1'b0;
        end else begin
            // Done one cycle after the last output write
            r_done <= (state == fc_ctrl_pkg::S_DRAIN) && i_layer_written;
            // Sticky, run request while busy
            if (i_run && r_run) begin
                r_err <= 1'b1;
            end
            case (state)
                fc_ctrl_pkg::S_IDLE: begin
                    if (i_run) begin
                        r_run <= 1'b1;
                        r_ich <= '0;
                        r_och <= '0;
                        state <= fc_ctrl_pkg::S_ISSUE;
                    end
                end
                // Single cycle, tile_start is high here
                fc_ctrl_pkg::S_ISSUE: begin
                    state <= fc_ctrl_pkg::S_WAIT_TILE;
                end
                fc_ctrl_pkg::S_WAIT_TILE: begin
                    if (tile.tile_done) begin
                        if (tile.last_ich) begin
                            r_ich <= '0;
                            if (r_och == OCH_W'(OCH_B - 1)) begin
                                // All tiles issued, wait for the requantizer
                                state <= fc_ctrl_pkg::S_DRAIN;
                            end else begin
                                r_och <= r_och + 1'b1;
                                state <= fc_ctrl_pkg::S_ISSUE;
                            end
                        end else begin
                            r_ich <= r_ich + 1'b1;
                            state <= fc_ctrl_pkg::S_ISSUE;
                        end
                    end
                end
                fc_ctrl_pkg::S_DRAIN: begin
                    if (i_layer_written) begin
                        // Run flag drops together with done
                        r_run <= 1'b0;
                        state <= fc_ctrl_pkg::S_IDLE;
                    end
                end
                default: state <= fc_ctrl_pkg::S_IDLE;
            endcase
        end
    end

    //======================================================================
    // Tile command
    //======================================================================
    assign tile.tile_start = (state == fc_ctrl_pkg::S_ISSUE);
    assign tile.first_ich  = (r_ich == '0);
    assign tile.last_ich   = (r_ich == ICH_W'(ICH_B - 1));

    // Input tile starts at ich * LANES
    assign tile.in_base = fc_ctrl_pkg::in_addr_t'(r_ich)
                        * fc_ctrl_pkg::in_addr_t'(fc_data_pkg::LANES);

    // First channel of the output block, at this input block
    assign tile.w_base  = fc_ctrl_pkg::w_addr_t'(r_och)
                        * fc_ctrl_pkg::w_addr_t'(OCH_T * ICH_B)
                        + fc_ctrl_pkg::w_addr_t'(r_ich);

    // Status
    assign o_idle   = !r_run;
    assign o_run    = r_run;
    assign o_done   = r_done;
    assign o_en_err = r_err;

endmodule

`default_nettype wire

/* fc_mac_engine.sv */
/*
 * MAC engine, buffers one input tile and accumulates OCH_T channels
 * against weight words read at a stride of ICH_B
 */

`default_nettype none

module fc_mac_engine #(
    parameter int ICH_B = 4,
    parameter int OCH_T = 4
) (
    input  logic                       clk,
    input  logic                       areset,
    fc_tile_if.mac                     tile,
    output fc_ctrl_pkg::in_addr_t      o_in_addr,
    output logic                       o_in_ce,
    input  fc_data_pkg::act_t          i_in_q,
    output fc_ctrl_pkg::w_addr_t       o_w_addr,
    output logic                       o_w_ce,
    input  fc_data_pkg::weight_word_t  i_w_q,
    output logic                       o_acc_valid,
    output fc_ctrl_pkg::och_idx_t      o_acc_idx,
    output fc_data_pkg::acc_t          o_acc_value
);

    localparam int LANES   = fc_data_pkg::LANES;
    localparam int W_BITS  = $bits(fc_data_pkg::weight_t);
    localparam int CNT_MAX = (LANES > OCH_T) ? LANES : OCH_T;
    localparam int CNT_W   = (CNT_MAX > 1) ? $clog2(CNT_MAX) : 1;

    fc_ctrl_pkg::mac_state_t state;
    logic [CNT_W-1:0]        r_cnt;
    fc_ctrl_pkg::in_addr_t   r_in_addr;
    fc_ctrl_pkg::w_addr_t    r_w_addr;
    fc_ctrl_pkg::och_idx_t   r_och_base;
    logic                    r_first;
    logic                    r_last;

    // Activation capture, one cycle behind the read
    logic                    r_in_ce_d;
    logic [CNT_W-1:0]        r_lane_d;
    fc_data_pkg::act_t       act_buf [LANES];

    // Pipeline tag, stage 1 holds the returning word, stage 2 the dot product
    logic                    r_v1;
    logic                    r_first1;
    logic                    r_last1;
    logic [CNT_W-1:0]        r_ch1;
    logic                    r_v2;
    logic                    r_first2;
    logic                    r_last2;
    logic [CNT_W-1:0]        r_ch2;

    logic signed [2*W_BITS-1:0] prod [LANES];
    fc_data_pkg::acc_t       dot;
    fc_data_pkg::acc_t       r_dot;
    fc_data_pkg::acc_t       acc_next;
    fc_data_pkg::acc_t       acc_bank [OCH_T];
    logic                    r_tile_done;

    //======================================================================
    // Read FSM, LANES activation reads then OCH_T weight reads
    //======================================================================
    always_ff @(posedge clk) begin
        if (areset) begin
            state <= fc_ctrl_pkg::M_IDLE;
            r_cnt <= '0;
        end else begin
            case (state)
                fc_ctrl_pkg::M_IDLE: begin
                    if (tile.tile_start) begin
                        r_cnt <= '0;
                        state <= fc_ctrl_pkg::M_LOAD;
                    end
                end
                fc_ctrl_pkg::M_LOAD: begin
                    if (r_cnt == CNT_W'(LANES - 1)) begin
                        r_cnt <= '0;
                        state <= fc_ctrl_pkg::M_MAC;
                    end else begin
                        r_cnt <= r_cnt + 1'b1;
                    end
                end
                fc_ctrl_pkg::M_MAC: begin
                    if (r_cnt == CNT_W'(OCH_T - 1)) begin
                        r_cnt <= '0;
                        state <= fc_ctrl_pkg::M_IDLE;
                    end else begin
                        r_cnt <= r_cnt + 1'b1;
                    end
                end
                default: state <= fc_ctrl_pkg::M_IDLE;
            endcase
        end
    end

    // Tile command latch and address walk
    always_ff @(posedge clk) begin
        if ((state == fc_ctrl_pkg::M_IDLE) && tile.tile_start) begin
            r_in_addr  <= tile.in_base;
            r_w_addr   <= tile.w_base;
            // Channel base recovered from the weight stride
            r_och_base <= fc_ctrl_pkg::och_idx_t'(tile.w_base
                          / fc_ctrl_pkg::w_addr_t'(ICH_B));
            r_first    <= tile.first_ich;
            r_last     <= tile.last_ich;
        end else if (state == fc_ctrl_pkg::M_LOAD) begin
            r_in_addr <= r_in_addr + 1'b1;
        end else if (state == fc_ctrl_pkg::M_MAC) begin
            r_w_addr <= r_w_addr + fc_ctrl_pkg::w_addr_t'(ICH_B);
        end
    end

    assign o_in_ce   = (state == fc_ctrl_pkg::M_LOAD);
    assign o_in_addr = r_in_addr;
    assign o_w_ce    = (state == fc_ctrl_pkg::M_MAC);
    assign o_w_addr  = r_w_addr;

    //======================================================================
    // Dot product of one weight word with the buffered tile
    //======================================================================
    always_comb begin
        dot = '0;
        for (int i = 0; i < LANES; i++) begin
            prod[i] = act_buf[i] * fc_data_pkg::weight_t'(i_w_q[i*W_BITS +: W_BITS]);
            dot     = dot + fc_data_pkg::acc_t'(prod[i]);
        end
    end

    // First input block replaces the stale partial sum
    assign acc_next = r_first2 ? r_dot : acc_bank[r_ch2] + r_dot;

    // Valid flags
    always_ff @(posedge clk) begin
        if (areset) begin
            r_in_ce_d   <= 1'b0;
            r_v1        <= 1'b0;
            r_v2        <= 1'b0;
            r_tile_done <= 1'b0;
        end else begin
            r_in_ce_d   <= o_in_ce;
            r_v1        <= o_w_ce;
            r_v2        <= r_v1;
            r_tile_done <= r_v2 && (r_ch2 == CNT_W'(OCH_T - 1));
        end
    end

    // Payload and tags
    always_ff @(posedge clk) begin
        r_lane_d <= r_cnt;
        if (r_in_ce_d) begin
            act_buf[r_lane_d] <= i_in_q;
        end
        r_ch1    <= r_cnt;
        r_first1 <= r_first;
        r_last1  <= r_last;
        r_ch2    <= r_ch1;
        r_first2 <= r_first1;
        r_last2  <= r_last1;
        r_dot    <= dot;
        if (r_v2) begin
            acc_bank[r_ch2] <= acc_next;
        end
    end

    // Finished sums go out with the last input block update
    assign o_acc_valid    = r_v2 && r_last2;
    assign o_acc_idx      = r_och_base + fc_ctrl_pkg::och_idx_t'(r_ch2);
    assign o_acc_value    = acc_next;
    assign tile.tile_done = r_tile_done;

endmodule

`default_nettype wire

/* fc_requant.sv */
/*
 * Requantizer, adds bias, rescales by right shift, ReLU and
 * saturation to 8 bits, then writes the output memory
 */

`default_nettype none

module fc_requant #(
    parameter int OCH_B       = 2,
    parameter int OCH_T       = 4,
    parameter int SCALE_SHIFT = 8,
    parameter int RELU        = 1
) (
    input  logic                  clk,
    input  logic                  areset,
    input  logic                  i_acc_valid,
    input  fc_ctrl_pkg::och_idx_t i_acc_idx,
    input  fc_data_pkg::acc_t     i_acc_value,
    output fc_ctrl_pkg::och_idx_t o_b_addr,
    output logic                  o_b_ce,
    input  fc_data_pkg::bias_t    i_b_q,
    output fc_ctrl_pkg::och_idx_t o_out_addr,
    output logic                  o_out_ce,
    output fc_data_pkg::act_t     o_out_d,
    output logic                  o_layer_written
);

    localparam int OCH = OCH_B * OCH_T;
    localparam int ACT_BITS = $bits(fc_data_pkg::act_t);
    localparam fc_data_pkg::acc_t SAT_HI = fc_data_pkg::acc_t'(2 ** (ACT_BITS - 1) - 1);
    localparam fc_data_pkg::acc_t SAT_LO = fc_data_pkg::acc_t'(-(2 ** (ACT_BITS - 1)));

    logic                  r_v1;
    fc_ctrl_pkg::och_idx_t r_idx1;
    fc_data_pkg::acc_t     r_acc1;
    fc_data_pkg::acc_t     biased;
    fc_data_pkg::acc_t     shifted;
    fc_data_pkg::act_t     quant;

    // Bias read issued with the incoming sum
    assign o_b_ce   = i_acc_valid;
    assign o_b_addr = i_acc_idx;

    //======================================================================
    // Rescale and clamp, bias arrives one cycle after the read
    //======================================================================
    always_comb begin
        biased  = r_acc1 + fc_data_pkg::acc_t'(i_b_q);
        shifted = biased >>> SCALE_SHIFT;
        if ((RELU != 0) && (shifted < 0)) begin
            quant = '0;
        end else if (shifted > SAT_HI) begin
            quant = fc_data_pkg::act_t'(SAT_HI);
        end else if (shifted < SAT_LO) begin
            quant = fc_data_pkg::act_t'(SAT_LO);
        end else begin
            quant = fc_data_pkg::act_t'(shifted);
        end
    end

    // Write strobes
    always_ff @(posedge clk) begin
        if (areset) begin
            r_v1            <= 1'b0;
            o_out_ce        <= 1'b0;
            o_layer_written <= 1'b0;
        end else begin
            r_v1            <= i_acc_valid;
            o_out_ce        <= r_v1;
            // Last channel of the layer
            o_layer_written <= r_v1 && (r_idx1 == fc_ctrl_pkg::och_idx_t'(OCH - 1));
        end
    end

    // Sum, index and output data
    always_ff @(posedge clk) begin
        r_idx1     <= i_acc_idx;
        r_acc1     <= i_acc_value;
        o_out_addr <= r_idx1;
        o_out_d    <= quant;
    end

endmodule

`default_nettype wire

/* fc_layer_top.sv */
/*
 * Fully connected layer, tile sequencer, MAC engine and requantizer
 */

`default_nettype none

module fc_layer_top #(
    parameter int ICH_B       = 4,
    parameter int OCH_B       = 2,
    parameter int OCH_T       = 4,
    parameter int SCALE_SHIFT = 8,
    parameter int RELU        = 1
) (
    input  logic                      clk,
    input  logic                      areset,
    input  logic                      i_run,
    output logic                      o_idle,
    output logic                      o_run,
    output logic                      o_done,
    output logic                      o_en_err,
    // Input feature map memory
    output fc_ctrl_pkg::in_addr_t     o_in_addr,
    output logic                      o_in_ce,
    input  fc_data_pkg::act_t         i_in_q,
    // Weight memory
    output fc_ctrl_pkg::w_addr_t      o_w_addr,
    output logic                      o_w_ce,
    input  fc_data_pkg::weight_word_t i_w_q,
    // Bias memory
    output fc_ctrl_pkg::och_idx_t     o_b_addr,
    output logic                      o_b_ce,
    input  fc_data_pkg::bias_t        i_b_q,
    // Output memory
    output fc_ctrl_pkg::och_idx_t     o_out_addr,
    output logic                      o_out_ce,
    output fc_data_pkg::act_t         o_out_d
);

    fc_tile_if tile_if ();

    // MAC engine to requantizer
    logic                  acc_valid;
    fc_ctrl_pkg::och_idx_t acc_idx;
    fc_data_pkg::acc_t     acc_value;
    logic                  layer_written;

    fc_tile_sequencer #(.ICH_B(ICH_B), .OCH_B(OCH_B), .OCH_T(OCH_T)) u_seq (
        .clk(clk), .areset(areset), .i_run(i_run), .i_layer_written(layer_written),
        .tile(tile_if.seq), .o_idle(o_idle), .o_run(o_run), .o_done(o_done),
        .o_en_err(o_en_err)
    );

    fc_mac_engine #(.ICH_B(ICH_B), .OCH_T(OCH_T)) u_mac (
        .clk(clk), .areset(areset), .tile(tile_if.mac),
        .o_in_addr(o_in_addr), .o_in_ce(o_in_ce), .i_in_q(i_in_q),
        .o_w_addr(o_w_addr), .o_w_ce(o_w_ce), .i_w_q(i_w_q),
        .o_acc_valid(acc_valid), .o_acc_idx(acc_idx), .o_acc_value(acc_value)
    );

    fc_requant #(
        .OCH_B(OCH_B), .OCH_T(OCH_T), .SCALE_SHIFT(SCALE_SHIFT), .RELU(RELU)
    ) u_requant (
        .clk(clk), .areset(areset),
        .i_acc_valid(acc_valid), .i_acc_idx(acc_idx), .i_acc_value(acc_value),
        .o_b_addr(o_b_addr), .o_b_ce(o_b_ce), .i_b_q(i_b_q),
        .o_out_addr(o_out_addr), .o_out_ce(o_out_ce), .o_out_d(o_out_d),
        .o_layer_written(layer_written)
    );

endmodule

`default_nettype wire

/* fc_layer_assert.sv */
/*
 * Bound checks on layer status and memory strobes
 */

`default_nettype none

module fc_layer_assert (
    input logic clk,
    input logic areset,
    input logic o_idle,
    input logic o_run,
    input logic o_done,
    input logic o_in_ce,
    input logic o_w_ce,
    input logic o_b_ce,
    input logic o_out_ce
);

    timeunit 1ns;
    timeprecision 1ps;

    // Done is a single cycle pulse
    done_pulse: assert property (@(posedge clk) disable iff (areset) o_done |=> !o_done)
        else $error("o_done high for more than one cycle");

    // Run ends only with the done pulse, idle returns at the same edge
    run_ends_with_done: assert property (@(posedge clk) disable iff (areset)
        $fell(o_run) |-> o_done)
        else $error("o_run dropped without o_done");

    // No memory traffic outside a run
    quiet_idle: assert property (@(posedge clk) disable iff (areset)
        o_idle |-> !(o_in_ce || o_w_ce || o_b_ce || o_out_ce))
        else $error("memory strobe active while idle");

endmodule

bind fc_layer_top fc_layer_assert u_assert (
    .clk(clk), .areset(areset), .o_idle(o_idle), .o_run(o_run), .o_done(o_done),
    .o_in_ce(o_in_ce), .o_w_ce(o_w_ce), .o_b_ce(o_b_ce), .o_out_ce(o_out_ce)
);

`default_nettype wire

/* tb_fc_layer.sv */
/*
 * Testbench for the fully connected layer
 * Read memory models, reference model, random and directed runs
 */

`default_nettype none

module tb_fc_layer;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ICH_B       = 4;
    localparam int OCH_B       = 2;
    localparam int OCH_T       = 4;
    localparam int SCALE_SHIFT = 8;
    localparam int RELU        = 1;
    localparam int LANES       = fc_data_pkg::LANES;
    localparam int ICH         = ICH_B * LANES;
    localparam int OCH         = OCH_B * OCH_T;
    localparam int NUM_RUNS    = 5;
    // Tiles times per-tile cycles, plus drain
    localparam int RUN_CYCLES  = OCH_B * ICH_B * (LANES + OCH_T + 4) + 20;
    localparam int MAX_CYCLES  = 4 * NUM_RUNS * RUN_CYCLES;
    localparam logic [31:0] SEED = 32'h829ca668;

    logic                      clk;
    logic                      areset;
    logic                      i_run;
    logic                      o_idle;
    logic                      o_run;
    logic                      o_done;
    logic                      o_en_err;
    fc_ctrl_pkg::in_addr_t     o_in_addr;
    logic                      o_in_ce;
    fc_data_pkg::act_t         i_in_q;
    fc_ctrl_pkg::w_addr_t      o_w_addr;
    logic                      o_w_ce;
    fc_data_pkg::weight_word_t i_w_q;
    fc_ctrl_pkg::och_idx_t     o_b_addr;
    logic                      o_b_ce;
    fc_data_pkg::bias_t        i_b_q;
    fc_ctrl_pkg::och_idx_t     o_out_addr;
    logic                      o_out_ce;
    fc_data_pkg::act_t         o_out_d;

    // Memory contents and pending read requests
    fc_data_pkg::act_t         in_mem [ICH];
    fc_data_pkg::weight_word_t w_mem [OCH * ICH_B];
    fc_data_pkg::bias_t        b_mem [OCH];
    fc_data_pkg::act_t         out_mem [OCH];
    int                        wr_cnt [OCH];
    logic                      in_req;
    logic                      w_req;
    logic                      b_req;
    fc_ctrl_pkg::in_addr_t     in_req_addr;
    fc_ctrl_pkg::w_addr_t      w_req_addr;
    fc_ctrl_pkg::och_idx_t     b_req_addr;
    int                        run_writes;
    int                        n_compared;
    int                        cycles;

    fc_layer_top #(
        .ICH_B(ICH_B), .OCH_B(OCH_B), .OCH_T(OCH_T), .SCALE_SHIFT(SCALE_SHIFT), .RELU(RELU)
    ) fc_layer_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //======================================================================
    // Reference model and compare tasks
    //======================================================================
    function automatic fc_data_pkg::act_t ref_out(input int och);
        int                        sum;
        fc_data_pkg::weight_word_t word;
        sum = 0;
        for (int i = 0; i < ICH; i++) begin
            // Input i sits in block i / LANES, byte lane i % LANES
            word = w_mem[och * ICH_B + i / LANES];
            sum += int'(in_mem[i]) * int'(fc_data_pkg::weight_t'(word[(i % LANES) * 8 +: 8]));
        end
        sum = (sum + int'(b_mem[och])) >>> SCALE_SHIFT;
        if ((RELU != 0) && (sum < 0)) begin
            sum = 0;
        end
        if (sum > 127) begin
            sum = 127;
        end else if (sum < -128) begin
            sum = -128;
        end
        return fc_data_pkg::act_t'(sum);
    endfunction

    task automatic report_fail(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_act(input fc_data_pkg::act_t got, input fc_data_pkg::act_t exp,
                             input string what);
        if (got !== exp) begin
            report_fail($sformatf("Fail %0t: %s, got %0d expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_fail($sformatf("Fail %0t: %s, got %b expected %b", $time, what, got, exp));
        end
    endtask

    //======================================================================
    // Memory models and output compare
    //======================================================================
    // Request seen at one falling edge is answered at the next
    always @(negedge clk) begin
        if (in_req) begin
            i_in_q <= in_mem[in_req_addr];
        end
        if (w_req) begin
            i_w_q <= w_mem[w_req_addr];
        end
        if (b_req) begin
            i_b_q <= b_mem[b_req_addr];
        end
        in_req      <= o_in_ce;
        in_req_addr <= o_in_addr;
        w_req       <= o_w_ce;
        w_req_addr  <= o_w_addr;
        b_req       <= o_b_ce;
        b_req_addr  <= o_b_addr;
    end

    always @(negedge clk) begin
        if (!areset && o_out_ce) begin
            check_flag(o_out_addr < OCH, 1'b1, "output address in range");
            check_act(o_out_d, ref_out(o_out_addr), $sformatf("channel %0d", o_out_addr));
            out_mem[o_out_addr] = o_out_d;
            wr_cnt[o_out_addr]++;
            run_writes++;
            n_compared++;
        end
        if (!areset && o_done) begin
            check_flag(run_writes == OCH, 1'b1, "all channels written before done");
            check_flag(o_idle, 1'b1, "idle together with done");
        end
    end

    // Watchdog
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        report_fail($sformatf("Timeout, layer still busy after %0d cycles", cycles));
    end

    //======================================================================
    // Stimulus
    //======================================================================
    // Mode 0 random, 1 large positive, 2 large negative weights
    task automatic fill_mems(input int mode);
        fc_data_pkg::weight_word_t word;
        for (int i = 0; i < ICH; i++) begin
            in_mem[i] = (mode == 0) ? fc_data_pkg::act_t'($urandom)
                                    : fc_data_pkg::act_t'(64 + $urandom % 64);
        end
        for (int k = 0; k < OCH * ICH_B; k++) begin
            for (int l = 0; l < LANES; l++) begin
                case (mode)
                    0:       word[l*8 +: 8] = 8'($urandom);
                    1:       word[l*8 +: 8] = 8'(64 + $urandom % 64);
                    default: word[l*8 +: 8] = 8'(-(64 + $urandom % 65));
                endcase
            end
            w_mem[k] = word;
        end
        for (int o = 0; o < OCH; o++) begin
            b_mem[o] = (mode == 0) ? fc_data_pkg::bias_t'($urandom)
                                   : fc_data_pkg::bias_t'($urandom % 256);
        end
    endtask

    task automatic do_run(input bit inject_err);
        for (int o = 0; o < OCH; o++) begin
            wr_cnt[o] = 0;
        end
        run_writes = 0;
        i_run = 1'b1;
        @(negedge clk);
        i_run = 1'b0;
        check_flag(o_run, 1'b1, "run flag after start");
        // A request while idle never raises the error flag
        check_flag(o_en_err, 1'b0, "error flag after start from idle");
        if (inject_err) begin
            // Second request while busy
            repeat (LANES + OCH_T) @(negedge clk);
            i_run = 1'b1;
            @(negedge clk);
            i_run = 1'b0;
            check_flag(o_en_err, 1'b1, "error flag after run while busy");
        end
        while (!o_done) begin
            @(negedge clk);
        end
        @(negedge clk);
        check_flag(o_done, 1'b0, "done lasts one cycle");
        check_flag(o_idle, 1'b1, "idle after done");
        for (int o = 0; o < OCH; o++) begin
            check_flag(wr_cnt[o] == 1, 1'b1, $sformatf("channel %0d written once", o));
        end
    endtask

    initial begin
        void'($urandom(SEED));
        areset     = 1'b1;
        i_run      = 1'b0;
        i_in_q     = '0;
        i_w_q      = '0;
        i_b_q      = '0;
        n_compared = 0;
        run_writes = 0;
        repeat (5) @(negedge clk);
        areset = 1'b0;
        @(negedge clk);
        check_flag(o_idle, 1'b1, "idle after reset");
        check_flag(o_run, 1'b0, "run after reset");
        check_flag(o_done, 1'b0, "done after reset");
        check_flag(o_en_err, 1'b0, "error after reset");
        check_flag(o_out_ce, 1'b0, "output write after reset");

        // Two random runs back to back
        fill_mems(0);
        do_run(1'b0);
        fill_mems(0);
        do_run(1'b0);

        // Positive overflow clips at the top of act_t
        fill_mems(1);
        do_run(1'b0);
        for (int o = 0; o < OCH; o++) begin
            check_act(out_mem[o], 8'sd127, $sformatf("saturated channel %0d", o));
        end
        // Negative sums vanish under ReLU
        fill_mems(2);
        do_run(1'b0);
        for (int o = 0; o < OCH; o++) begin
            check_act(out_mem[o], 8'sd0, $sformatf("ReLU channel %0d", o));
        end

        fill_mems(0);
        do_run(1'b1);
        check_flag(o_en_err, 1'b1, "error flag sticky after run");
        areset = 1'b1;
        @(negedge clk);
        areset = 1'b0;
        @(negedge clk);
        check_flag(o_en_err, 1'b0, "error flag cleared by reset");

        if (n_compared == NUM_RUNS * OCH) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            report_fail($sformatf("Fail %0t: %0d writes compared, expected %0d",
                                  $time, n_compared, NUM_RUNS * OCH));
        end
    end

endmodule

`default_nettype wire

/* src.f */
fc_data_pkg.sv
fc_ctrl_pkg.sv
fc_tile_if.sv
fc_tile_sequencer.sv
fc_mac_engine.sv
fc_requant.sv
fc_layer_top.sv
fc_layer_assert.sv
tb_fc_layer.sv

/* Bender.yml */
package:
  name: fc_layer

dependencies: {}

sources:
  - fc_data_pkg.sv
  - fc_ctrl_pkg.sv
  - fc_tile_if.sv
  - fc_tile_sequencer.sv
  - fc_mac_engine.sv
  - fc_requant.sv
  - fc_layer_top.sv
  - target: test
    files:
      - fc_layer_assert.sv
      - tb_fc_layer.sv
